/* common/tsn_gate_pkg.sv */
`default_nettype none

package tsn_gate_pkg;

    // default number of control list entries
    localparam int GCL_DEPTH = 16;

    typedef logic [3:0] gcl_idx_t;          // list entry number

    // entry duration in clock cycles
    // an entry holds for interval + 1 cycles
    typedef logic [15:0] gcl_interval_t;

endpackage

`default_nettype wire

/* common/tsn_shaper_pkg.sv */
`default_nettype none

package tsn_shaper_pkg;

    // default queue count per egress port
    localparam int QUEUE_NUM = 8;

    // per-queue bit vector, bit 7 is the highest priority
    typedef logic [7:0] queue_mask_t;

    typedef logic [2:0] queue_idx_t;        // queue number, 0..7

    // credit step per clock cycle, unsigned
    typedef logic [7:0] slope_t;

    typedef logic [15:0] threshold_t;       // clamp magnitude, unsigned

    // signed credit, two bits above the threshold width
    // keeps sum and difference with a slope from overflowing
    typedef logic signed [17:0] credit_t;

    // scheduling discipline of the arbiter
    typedef enum logic {
        ARB_STRICT      = 1'b0,             // highest non-empty index wins
        ARB_ROUND_ROBIN = 1'b1              // rotate after the last grant
    } arb_mode_e;

endpackage

`default_nettype wire

/* filelist.f */
common/tsn_shaper_pkg.sv
common/tsn_gate_pkg.sv
qav/qav_credit_shaper.sv
qbv/gate_list_ram.sv
qbv/gate_cycle_engine.sv
source/qos_arbiter.sv
source/tsn_scheduler_top.sv
tb/tb_tsn_scheduler.sv

/* qav/qav_credit_shaper.sv */
`timescale 1ns/10ps
`default_nettype none

// Qav credit based shaper, one credit accumulator per priority queue
module qav_credit_shaper #(
    parameter int NUM_QUEUES = tsn_shaper_pkg::QUEUE_NUM
) (
    input  wire                              i_clk,
    input  wire                              i_rst,
    input  wire tsn_shaper_pkg::slope_t      i_idle_slope   [NUM_QUEUES], // credit gain
    input  wire tsn_shaper_pkg::slope_t      i_send_slope   [NUM_QUEUES], // credit loss
    input  wire tsn_shaper_pkg::threshold_t  i_hi_threshold [NUM_QUEUES], // upper clamp
    input  wire tsn_shaper_pkg::threshold_t  i_lo_threshold [NUM_QUEUES], // lower clamp magnitude
    input  wire                              i_qav_en,
    input  wire                              i_cfg_vld,     // latches config, clears credits
    input  wire tsn_shaper_pkg::queue_mask_t i_fifo_empty,
    input  wire                              i_tx_valid,    // beat on the wire this cycle
    input  wire tsn_shaper_pkg::queue_idx_t  i_tx_queue,    // queue owning that beat
    output tsn_shaper_pkg::queue_mask_t      o_eligible
);

    localparam tsn_shaper_pkg::queue_mask_t Q_MASK =
        tsn_shaper_pkg::queue_mask_t'((1 << NUM_QUEUES) - 1);

    tsn_shaper_pkg::slope_t     cfg_idle [NUM_QUEUES];
    tsn_shaper_pkg::slope_t     cfg_send [NUM_QUEUES];
    tsn_shaper_pkg::threshold_t cfg_hi   [NUM_QUEUES];
    tsn_shaper_pkg::threshold_t cfg_lo   [NUM_QUEUES];
    logic                       cfg_en;

    logic [NUM_QUEUES-1:0]      elig_nxt;   // credit >= 0 per queue

    // shadow copy of the shaper config
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cfg_idle <= '{default: '0};
            cfg_send <= '{default: '0};
            cfg_hi   <= '{default: '0};
            cfg_lo   <= '{default: '0};
            cfg_en   <= 1'b0;
        end else if (i_cfg_vld) begin
            cfg_idle <= i_idle_slope;
            cfg_send <= i_send_slope;
            cfg_hi   <= i_hi_threshold;
            cfg_lo   <= i_lo_threshold;
            cfg_en   <= i_qav_en;
        end
    end

    for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
        tsn_shaper_pkg::credit_t credit;
        tsn_shaper_pkg::credit_t credit_nxt;
        tsn_shaper_pkg::credit_t hi_lim;
        tsn_shaper_pkg::credit_t lo_lim;
        tsn_shaper_pkg::credit_t up;
        tsn_shaper_pkg::credit_t down;
        logic                    tx_now;

        assign hi_lim = tsn_shaper_pkg::credit_t'(cfg_hi[q]);
        assign lo_lim = -tsn_shaper_pkg::credit_t'(cfg_lo[q]);   // negative floor
        assign up     = credit + tsn_shaper_pkg::credit_t'(cfg_idle[q]);
        assign down   = credit - tsn_shaper_pkg::credit_t'(cfg_send[q]);
        assign tx_now = i_tx_valid && (i_tx_queue == q);

        always_comb begin
            if (tx_now) begin
                credit_nxt = (down < lo_lim) ? lo_lim : down;  // sending, drain
            end else if (!i_fifo_empty[q] || (credit < 0)) begin
                // waiting or recovering, refill up to the cap
                credit_nxt = (up > hi_lim) ? hi_lim : up;
            end else begin
                credit_nxt = '0;                // empty queue drops positive credit
            end
        end

        always_ff @(posedge i_clk) begin
            if (i_rst || i_cfg_vld || !cfg_en) begin
                credit <= '0;
            end else begin
                credit <= credit_nxt;
            end
        end

        assign elig_nxt[q] = !cfg_en || (credit >= 0);

        // clamp holds across config reloads too
        a_credit_range: assert property (@(posedge i_clk) disable iff (i_rst)
            (credit <= hi_lim) && (credit >= lo_lim));
    end

    // one cycle behind the credit
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_eligible <= Q_MASK;               // credits start at zero
        end else begin
            o_eligible <= tsn_shaper_pkg::queue_mask_t'(elig_nxt);
        end
    end

endmodule

`default_nettype wire

/* qbv/gate_cycle_engine.sv */
`timescale 1ns/10ps
`default_nettype none

// Qbv gate cycle, steps through the control list on local cycle counts
module gate_cycle_engine #(
    parameter int LIST_DEPTH = tsn_gate_pkg::GCL_DEPTH
) (
    input  wire                                i_clk,
    input  wire                                i_rst,
    input  wire                                i_qbv_en,
    input  wire                                i_start,          // start strobe
    input  wire tsn_gate_pkg::gcl_idx_t        i_list_len,       // last active entry
    input  wire tsn_shaper_pkg::queue_mask_t   i_entry_gates,    // ram read data
    input  wire tsn_gate_pkg::gcl_interval_t   i_entry_interval,
    output tsn_gate_pkg::gcl_idx_t             o_entry_idx,      // ram read index
    output tsn_shaper_pkg::queue_mask_t        o_gate_open
);

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } state_e;

    state_e                        state;
    tsn_gate_pkg::gcl_idx_t        idx;         // entry currently applied
    tsn_gate_pkg::gcl_idx_t        nxt_idx;
    tsn_gate_pkg::gcl_interval_t   cnt;         // cycles left in this entry
    logic                          load;

    // countdown expired, next entry goes live on this edge
    assign load = (state == RUN) && (cnt == '0);

    // wrap after the last active entry or the end of the ram
    assign nxt_idx = ((idx >= i_list_len) || (idx == LIST_DEPTH - 1)) ? '0 : idx + 1'b1;

    // look one entry ahead while loading
    assign o_entry_idx = load ? nxt_idx : idx;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= IDLE;
            idx         <= '0;
            cnt         <= '0;
            o_gate_open <= '1;                  // all open until started
        end else if (!i_qbv_en) begin
            state       <= IDLE;
            o_gate_open <= '1;
        end else if (i_start) begin
            // park on the last entry so the first load wraps to entry 0
            state       <= RUN;
            idx         <= i_list_len;
            cnt         <= '0;
            o_gate_open <= '1;
        end else begin
            case (state)
                RUN: begin
                    if (load) begin
                        idx         <= nxt_idx;
                        cnt         <= i_entry_interval;
                        o_gate_open <= i_entry_gates;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    o_gate_open <= '1;          // idle, gates stay open
                end
            endcase
        end
    end

    a_idx_in_list: assert property (@(posedge i_clk) disable iff (i_rst)
        (state == RUN) |-> (idx <= i_list_len));

endmodule

`default_nettype wire

/* qbv/gate_list_ram.sv */
`timescale 1ns/10ps
`default_nettype none

// Qbv gate control list storage
// strobe write, asynchronous read by entry index
module gate_list_ram #(
    parameter int LIST_DEPTH = tsn_gate_pkg::GCL_DEPTH
) (
    input  wire                                i_clk,
    input  wire                                i_wr,            // single cycle write strobe
    input  wire tsn_gate_pkg::gcl_idx_t        i_wr_idx,
    input  wire tsn_shaper_pkg::queue_mask_t   i_wr_gates,      // 1 = gate open
    input  wire tsn_gate_pkg::gcl_interval_t   i_wr_interval,
    input  wire tsn_gate_pkg::gcl_idx_t        i_rd_idx,
    output tsn_shaper_pkg::queue_mask_t        o_rd_gates,
    output tsn_gate_pkg::gcl_interval_t        o_rd_interval
);

    tsn_shaper_pkg::queue_mask_t   gates_mem    [LIST_DEPTH];
    tsn_gate_pkg::gcl_interval_t   interval_mem [LIST_DEPTH];

    logic wr_in_range;
    logic rd_in_range;

    // index type may be wider than the list
    assign wr_in_range = (i_wr_idx < LIST_DEPTH);
    assign rd_in_range = (i_rd_idx < LIST_DEPTH);

    always_ff @(posedge i_clk) begin
        if (i_wr && wr_in_range) begin
            gates_mem[i_wr_idx]    <= i_wr_gates;
            interval_mem[i_wr_idx] <= i_wr_interval;
        end
    end

    // out of range reads look like an open, one cycle entry
    always_comb begin
        if (rd_in_range) begin
            o_rd_gates    = gates_mem[i_rd_idx];
            o_rd_interval = interval_mem[i_rd_idx];
        end else begin
            o_rd_gates    = '1;
            o_rd_interval = '0;
        end
    end

endmodule

`default_nettype wire

/* source/qos_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

// egress queue pick with two register stages from request to grant
module qos_arbiter #(
    parameter int NUM_QUEUES = tsn_shaper_pkg::QUEUE_NUM
) (
    input  wire                                i_clk,
    input  wire                                i_rst,
    input  wire                                i_req,          // scheduling request strobe
    input  wire tsn_shaper_pkg::queue_mask_t   i_fifo_empty,
    input  wire tsn_shaper_pkg::queue_mask_t   i_eligible,     // from the shaper
    input  wire tsn_shaper_pkg::queue_mask_t   i_gate_open,    // from the gate engine
    input  wire tsn_shaper_pkg::arb_mode_e     i_mode,
    output tsn_shaper_pkg::queue_mask_t        o_grant,        // one-hot or zero
    output logic                               o_grant_vld
);

    localparam tsn_shaper_pkg::queue_mask_t Q_MASK =
        tsn_shaper_pkg::queue_mask_t'((1 << NUM_QUEUES) - 1);

    logic                          req_q;
    tsn_shaper_pkg::queue_mask_t   cand_q;     // non-empty, eligible and open
    tsn_shaper_pkg::queue_idx_t    last_q;     // last granted queue
    tsn_shaper_pkg::queue_idx_t    pick;
    logic                          found;

    // stage 1 freezes the masks with the request
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= i_req;
        end
    end

    always_ff @(posedge i_clk) begin
        cand_q <= ~i_fifo_empty & i_eligible & i_gate_open & Q_MASK;
    end

    always_comb begin
        int unsigned slot;
        slot  = 0;
        pick  = '0;
        found = 1'b0;
        if (i_mode == tsn_shaper_pkg::ARB_STRICT) begin
            for (int i = 0; i < NUM_QUEUES; i++) begin
                if (cand_q[i]) begin
                    pick  = tsn_shaper_pkg::queue_idx_t'(i);    // later hit is higher
                    found = 1'b1;
                end
            end
        end else begin
            // walk down so the nearest slot above last_q wins
            for (int off = NUM_QUEUES; off >= 1; off--) begin
                slot = (last_q + off) % NUM_QUEUES;
                if (cand_q[slot]) begin
                    pick  = tsn_shaper_pkg::queue_idx_t'(slot);
                    found = 1'b1;
                end
            end
        end
    end

    // stage 2 registers the grant
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_grant_vld <= 1'b0;
            o_grant     <= '0;
            last_q      <= tsn_shaper_pkg::queue_idx_t'(NUM_QUEUES - 1);  // first rr pick is 0
        end else begin
            o_grant_vld <= req_q;
            o_grant     <= (req_q && found) ? tsn_shaper_pkg::queue_mask_t'(1) << pick : '0;
            if (req_q && found) begin
                last_q <= pick;                 // empty picks leave the pointer alone
            end
        end
    end

    // grant is one-hot or zero and always one of the frozen candidates
    a_grant_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0(o_grant) && ((o_grant & ~$past(cand_q)) == '0));

endmodule

`default_nettype wire

/* source/tsn_scheduler_top.sv */
`timescale 1ns/10ps
`default_nettype none

// per-port egress scheduler, Qav shaper + Qbv gates + QoS pick
module tsn_scheduler_top #(
    parameter int NUM_QUEUES = tsn_shaper_pkg::QUEUE_NUM,   // priority fifos per port
    parameter int LIST_DEPTH = tsn_gate_pkg::GCL_DEPTH      // gate control list size
) (
    input  wire                                i_clk,
    input  wire                                i_rst,
    // shaper config
    input  wire tsn_shaper_pkg::slope_t        i_idle_slope   [NUM_QUEUES],
    input  wire tsn_shaper_pkg::slope_t        i_send_slope   [NUM_QUEUES],
    input  wire tsn_shaper_pkg::threshold_t    i_hi_threshold [NUM_QUEUES],
    input  wire tsn_shaper_pkg::threshold_t    i_lo_threshold [NUM_QUEUES],
    input  wire                                i_qav_en,
    input  wire                                i_cfg_vld,
    // mac side activity
    input  wire                                i_tx_valid,
    input  wire tsn_shaper_pkg::queue_idx_t    i_tx_queue,
    // gate list writes and control
    input  wire                                i_gcl_wr,
    input  wire tsn_gate_pkg::gcl_idx_t        i_gcl_wr_idx,
    input  wire tsn_shaper_pkg::queue_mask_t   i_gcl_wr_gates,
    input  wire tsn_gate_pkg::gcl_interval_t   i_gcl_wr_interval,
    input  wire tsn_gate_pkg::gcl_idx_t        i_gcl_len,      // active entries minus one
    input  wire                                i_qbv_en,
    input  wire                                i_gcl_start,
    // scheduling
    input  wire tsn_shaper_pkg::queue_mask_t   i_fifo_empty,   // crossbar fifo status
    input  wire tsn_shaper_pkg::arb_mode_e     i_arb_mode,
    input  wire                                i_sched_req,
    output wire tsn_shaper_pkg::queue_mask_t   o_sched_grant,
    output wire                                o_sched_grant_vld
);

    wire tsn_shaper_pkg::queue_mask_t   qav_eligible;   // credit >= 0 per queue
    wire tsn_shaper_pkg::queue_mask_t   gate_open;      // current gate state
    wire tsn_gate_pkg::gcl_idx_t        entry_idx;
    wire tsn_shaper_pkg::queue_mask_t   entry_gates;
    wire tsn_gate_pkg::gcl_interval_t   entry_interval;

    qav_credit_shaper #(
        .NUM_QUEUES       (NUM_QUEUES)
    ) qav_credit_shaper_inst (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_idle_slope     (i_idle_slope),
        .i_send_slope     (i_send_slope),
        .i_hi_threshold   (i_hi_threshold),
        .i_lo_threshold   (i_lo_threshold),
        .i_qav_en         (i_qav_en),
        .i_cfg_vld        (i_cfg_vld),
        .i_fifo_empty     (i_fifo_empty),
        .i_tx_valid       (i_tx_valid),
        .i_tx_queue       (i_tx_queue),
        .o_eligible       (qav_eligible)
    );

    gate_list_ram #(
        .LIST_DEPTH       (LIST_DEPTH)
    ) gate_list_ram_inst (
        .i_clk            (i_clk),
        .i_wr             (i_gcl_wr),
        .i_wr_idx         (i_gcl_wr_idx),
        .i_wr_gates       (i_gcl_wr_gates),
        .i_wr_interval    (i_gcl_wr_interval),
        .i_rd_idx         (entry_idx),
        .o_rd_gates       (entry_gates),
        .o_rd_interval    (entry_interval)
    );

    gate_cycle_engine #(
        .LIST_DEPTH       (LIST_DEPTH)
    ) gate_cycle_engine_inst (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_qbv_en         (i_qbv_en),
        .i_start          (i_gcl_start),
        .i_list_len       (i_gcl_len),
        .i_entry_gates    (entry_gates),
        .i_entry_interval (entry_interval),
        .o_entry_idx      (entry_idx),
        .o_gate_open      (gate_open)
    );

    qos_arbiter #(
        .NUM_QUEUES       (NUM_QUEUES)
    ) qos_arbiter_inst (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_req            (i_sched_req),
        .i_fifo_empty     (i_fifo_empty),
        .i_eligible       (qav_eligible),
        .i_gate_open      (gate_open),
        .i_mode           (i_arb_mode),
        .o_grant          (o_sched_grant),
        .o_grant_vld      (o_sched_grant_vld)
    );

endmodule

`default_nettype wire

/* tb/tb_tsn_scheduler.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_tsn_scheduler;

    localparam int NUM_QUEUES  = tsn_shaper_pkg::QUEUE_NUM;
    localparam int LIST_DEPTH  = tsn_gate_pkg::GCL_DEPTH;
    localparam int TOP_Q       = NUM_QUEUES - 1;      // queue 7, highest priority
    localparam int CYCLE_LIMIT = 4000;                // all tests need well under 1000

    logic                          clk;
    logic                          rst;
    tsn_shaper_pkg::slope_t        idle_slope   [NUM_QUEUES];
    tsn_shaper_pkg::slope_t        send_slope   [NUM_QUEUES];
    tsn_shaper_pkg::threshold_t    hi_threshold [NUM_QUEUES];
    tsn_shaper_pkg::threshold_t    lo_threshold [NUM_QUEUES];
    logic                          qav_en;
    logic                          cfg_vld;
    logic                          tx_valid;
    tsn_shaper_pkg::queue_idx_t    tx_queue;
    logic                          gcl_wr;
    tsn_gate_pkg::gcl_idx_t        gcl_wr_idx;
    tsn_shaper_pkg::queue_mask_t   gcl_wr_gates;
    tsn_gate_pkg::gcl_interval_t   gcl_wr_interval;
    tsn_gate_pkg::gcl_idx_t        gcl_len;
    logic                          qbv_en;
    logic                          gcl_start;
    tsn_shaper_pkg::queue_mask_t   fifo_empty;
    tsn_shaper_pkg::arb_mode_e     arb_mode;
    logic                          sched_req;
    tsn_shaper_pkg::queue_mask_t   sched_grant;
    logic                          sched_grant_vld;

    integer seed = 30815;
    int     checks = 0;
    int     errors = 0;
    int     cycle_count = 0;
    int     rr_last = NUM_QUEUES - 1;                 // model of the rr pointer, reset value

    tsn_scheduler_top #(
        .NUM_QUEUES        (NUM_QUEUES),
        .LIST_DEPTH        (LIST_DEPTH)
    ) dut (
        .i_clk             (clk),
        .i_rst             (rst),
        .i_idle_slope      (idle_slope),
        .i_send_slope      (send_slope),
        .i_hi_threshold    (hi_threshold),
        .i_lo_threshold    (lo_threshold),
        .i_qav_en          (qav_en),
        .i_cfg_vld         (cfg_vld),
        .i_tx_valid        (tx_valid),
        .i_tx_queue        (tx_queue),
        .i_gcl_wr          (gcl_wr),
        .i_gcl_wr_idx      (gcl_wr_idx),
        .i_gcl_wr_gates    (gcl_wr_gates),
        .i_gcl_wr_interval (gcl_wr_interval),
        .i_gcl_len         (gcl_len),
        .i_qbv_en          (qbv_en),
        .i_gcl_start       (gcl_start),
        .i_fifo_empty      (fifo_empty),
        .i_arb_mode        (arb_mode),
        .i_sched_req       (sched_req),
        .o_sched_grant     (sched_grant),
        .o_sched_grant_vld (sched_grant_vld)
    );

    always #4 clk = ~clk;                             // 8 ns period

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("test %s finished, %0d mismatches", name, errors - err_start);
    endtask

    // highest set index, -1 when nothing is set
    function automatic int highest_set(input tsn_shaper_pkg::queue_mask_t m);
        int idx;
        idx = -1;
        for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
            if (m[i] && (idx < 0)) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // first set index above last, wrapping
    function automatic int next_after(input tsn_shaper_pkg::queue_mask_t m, input int last);
        int idx;
        int slot;
        idx = -1;
        for (int off = 1; off <= NUM_QUEUES; off++) begin
            slot = (last + off) % NUM_QUEUES;
            if (m[slot] && (idx < 0)) begin
                idx = slot;
            end
        end
        return idx;
    endfunction

    function automatic tsn_shaper_pkg::queue_mask_t idx_to_mask(input int idx);
        if (idx < 0) begin
            return '0;                                // nothing eligible
        end
        return tsn_shaper_pkg::queue_mask_t'(1) << idx;
    endfunction

    // one strict request, allowed = eligible & open as the model sees it
    task automatic single_request(input tsn_shaper_pkg::queue_mask_t empty,
                                  input tsn_shaper_pkg::queue_mask_t allowed);
        int exp_idx;
        exp_idx = highest_set(~empty & allowed);
        @(negedge clk);
        fifo_empty = empty;
        sched_req  = 1'b1;
        @(negedge clk);
        sched_req = 1'b0;
        check_value("o_sched_grant_vld", sched_grant_vld, 1'b0);     // not yet
        @(negedge clk);
        check_value("o_sched_grant_vld", sched_grant_vld, 1'b1);     // two edges later
        check_value("o_sched_grant", sched_grant, idx_to_mask(exp_idx));
        if (exp_idx >= 0) begin
            rr_last = exp_idx;                        // pointer moves on any non-zero grant
        end
        @(negedge clk);
        check_value("o_sched_grant_vld", sched_grant_vld, 1'b0);     // single cycle only
    endtask

    task automatic write_gate_entry(input int idx, input tsn_shaper_pkg::queue_mask_t gates,
                                    input int interval);
        @(negedge clk);
        gcl_wr          = 1'b1;
        gcl_wr_idx      = tsn_gate_pkg::gcl_idx_t'(idx);
        gcl_wr_gates    = gates;
        gcl_wr_interval = tsn_gate_pkg::gcl_interval_t'(interval);
        @(negedge clk);
        gcl_wr = 1'b0;
    endtask

    task automatic reset_idle_test();
        int err_start;
        err_start = errors;
        repeat (4) begin
            @(negedge clk);
            check_value("o_sched_grant_vld", sched_grant_vld, 1'b0);
            check_value("o_sched_grant", sched_grant, 8'h00);
        end
        report_test("reset", err_start);
    endtask

    task automatic strict_priority_test();
        int err_start;
        err_start = errors;
        arb_mode = tsn_shaper_pkg::ARB_STRICT;
        for (int n = 0; n < 20; n++) begin
            single_request(tsn_shaper_pkg::queue_mask_t'($random(seed)), 8'hFF);
        end
        single_request(8'hFF, 8'hFF);                 // all empty, vld with zero grant
        report_test("strict_priority", err_start);
    endtask

    task automatic round_robin_test();
        int err_start;
        int exp_idx;
        tsn_shaper_pkg::queue_mask_t seen;
        err_start = errors;
        seen      = '0;
        @(negedge clk);
        arb_mode   = tsn_shaper_pkg::ARB_ROUND_ROBIN;
        fifo_empty = '0;
        // requests at steps 0..7, grants show at steps 2..9
        for (int i = 0; i <= 10; i++) begin
            @(negedge clk);
            if ((i >= 2) && (i <= 9)) begin
                exp_idx = next_after(8'hFF, rr_last);
                rr_last = exp_idx;
                check_value("o_sched_grant_vld", sched_grant_vld, 1'b1);
                check_value("o_sched_grant", sched_grant, idx_to_mask(exp_idx));
                seen = seen | sched_grant;
            end else begin
                check_value("o_sched_grant_vld", sched_grant_vld, 1'b0);
            end
            sched_req = (i < 8);
        end
        check_value("rr queues covered", seen, 8'hFF);
        report_test("round_robin", err_start);
    endtask

    task automatic gate_list_test();
        int err_start;
        err_start = errors;
        arb_mode  = tsn_shaper_pkg::ARB_STRICT;
        write_gate_entry(0, 8'h0F, 99);               // interval + 1 = 100 cycles
        write_gate_entry(1, 8'hF0, 99);
        @(negedge clk);
        gcl_len   = 4'd1;
        qbv_en    = 1'b1;
        gcl_start = 1'b1;
        @(negedge clk);
        gcl_start = 1'b0;
        repeat (40) @(negedge clk);                   // middle of entry 0
        single_request(8'h00, 8'h0F);
        single_request(tsn_shaper_pkg::queue_mask_t'($random(seed)), 8'h0F);
        repeat (100) @(negedge clk);                  // middle of entry 1
        single_request(8'h00, 8'hF0);
        single_request(tsn_shaper_pkg::queue_mask_t'($random(seed)), 8'hF0);
        @(negedge clk);
        qbv_en = 1'b0;                                // back to all open
        repeat (2) @(negedge clk);
        report_test("gate_list", err_start);
    endtask

    task automatic credit_shaper_test();
        int err_start;
        err_start = errors;
        @(negedge clk);
        fifo_empty = 8'h80;                           // q7 empty, credit sits at zero
        for (int q = 0; q < NUM_QUEUES; q++) begin
            idle_slope[q]   = (q == TOP_Q) ? 8'd1 : 8'd0;
            send_slope[q]   = (q == TOP_Q) ? 8'd4 : 8'd0;
            hi_threshold[q] = 16'd1000;
            lo_threshold[q] = 16'd1000;
        end
        qav_en  = 1'b1;
        cfg_vld = 1'b1;
        @(negedge clk);
        cfg_vld  = 1'b0;
        tx_valid = 1'b1;
        tx_queue = tsn_shaper_pkg::queue_idx_t'(TOP_Q);
        repeat (50) @(negedge clk);                   // credit down to -200
        tx_valid = 1'b0;
        single_request(8'h00, 8'h7F);                 // q7 not eligible
        repeat (220) @(negedge clk);                  // +1 per cycle back above zero
        single_request(8'h00, 8'hFF);
        report_test("credit_shaper", err_start);
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        qav_en          = 1'b0;
        cfg_vld         = 1'b0;
        tx_valid        = 1'b0;
        tx_queue        = '0;
        gcl_wr          = 1'b0;
        gcl_wr_idx      = '0;
        gcl_wr_gates    = '0;
        gcl_wr_interval = '0;
        gcl_len         = '0;
        qbv_en          = 1'b0;
        gcl_start       = 1'b0;
        fifo_empty      = 8'hFF;
        arb_mode        = tsn_shaper_pkg::ARB_STRICT;
        sched_req       = 1'b0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            idle_slope[q]   = '0;
            send_slope[q]   = '0;
            hi_threshold[q] = '0;
            lo_threshold[q] = '0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        reset_idle_test();
        strict_priority_test();
        round_robin_test();
        gate_list_test();
        credit_shaper_test();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
